// File: hw/asg_pkg.sv
// widths, bus and configuration types and the register map shared by all generator blocks
`default_nettype none

package asg_pkg;

  ////////////////////
  // widths

  // table address, integer part of the read pointer
  localparam int unsigned ASG_CWM = 8;
  // fraction part of the read pointer
  localparam int unsigned ASG_CWF = 8;
  // burst length counter
  localparam int unsigned ASG_CWL = 16;
  // burst repeat counter
  localparam int unsigned ASG_CWN = 8;
  // sample width toward the DAC
  localparam int unsigned ASG_DW  = 14;
  // bus word address, top bit picks table over registers
  localparam int unsigned ASG_AW  = 10;

  ////////////////////
  // bus and control words

  // one strobe request from the register bus
  typedef struct packed {
    logic              wen;
    logic              ren;
    logic [ASG_AW-1:0] addr;
    logic [31:0]       wdata;
  } asg_bus_req_t;

  // configuration, siz is the last table index
  // stp and off are fixed point u8.8
  typedef struct packed {
    logic                       ben;
    logic                       inf;
    logic [7:0]                 trg_msk;
    logic [ASG_CWM+ASG_CWF-1:0] siz;
    logic [ASG_CWM+ASG_CWF-1:0] stp;
    logic [ASG_CWM+ASG_CWF-1:0] off;
    logic [ASG_CWM-1:0]         bdl;
    logic [ASG_CWL-1:0]         bln;
    logic [ASG_CWN-1:0]         bnm;
  } asg_cfg_t;

  // status, read back as one word with run on bit 24
  typedef struct packed {
    logic               run;
    logic [ASG_CWL-1:0] bln;
    logic [ASG_CWN-1:0] bnm;
  } asg_sts_t;

  // per-cycle control from the burst FSM
  typedef struct packed {
    logic trg;
    logic aen;
    logic run;
    logic lst;
    logic rdy;
  } asg_ctl_t;

  ////////////////////
  // register word indices, below the table window
  localparam logic [ASG_AW-2:0] REG_CTL = 'd0;
  localparam logic [ASG_AW-2:0] REG_TRG = 'd1;
  localparam logic [ASG_AW-2:0] REG_SIZ = 'd2;
  localparam logic [ASG_AW-2:0] REG_STP = 'd3;
  localparam logic [ASG_AW-2:0] REG_OFF = 'd4;
  localparam logic [ASG_AW-2:0] REG_BDL = 'd5;
  localparam logic [ASG_AW-2:0] REG_BLN = 'd6;
  localparam logic [ASG_AW-2:0] REG_BNM = 'd7;
  localparam logic [ASG_AW-2:0] REG_STS = 'd8;

endpackage

`default_nettype wire

// File: hw/asg_regs.sv
// register bank on the strobe bus, holds the configuration and answers read-back one cycle later
`default_nettype none

module asg_regs #(
  parameter int unsigned TN = 1
) (
  input  logic                       sto,
  input  logic                       ctl_rst,
  input  asg_pkg::asg_bus_req_t      bus_req,
  input  asg_pkg::asg_sts_t          sts,
  input  logic [asg_pkg::ASG_DW-1:0] tbl_rdata,
  output asg_pkg::asg_cfg_t          cfg,
  output logic                       tbl_we,
  output logic [31:0]                rdata,
  output logic                       ack
);
  import asg_pkg::*;

  // only the low TN mask bits exist
  localparam logic [7:0] TRG_VLD = 8'((2 ** TN) - 1);

  logic              sel_tbl;
  logic [ASG_AW-2:0] idx;
  logic [31:0]       reg_word;
  logic              rd_tbl;
  logic [31:0]       rd_reg;

  // address decode
  assign sel_tbl = bus_req.addr[ASG_AW-1];
  assign idx     = bus_req.addr[ASG_AW-2:0];
  // table writes go straight to the memory
  assign tbl_we  = bus_req.wen & sel_tbl;

  ////////////////////
  // read-back select
  always_comb begin
    case (idx)
      REG_CTL: reg_word = {30'd0, cfg.inf, cfg.ben};
      REG_TRG: reg_word = 32'(cfg.trg_msk);
      REG_SIZ: reg_word = 32'(cfg.siz);
      REG_STP: reg_word = 32'(cfg.stp);
      REG_OFF: reg_word = 32'(cfg.off);
      REG_BDL: reg_word = 32'(cfg.bdl);
      REG_BLN: reg_word = 32'(cfg.bln);
      REG_BNM: reg_word = 32'(cfg.bnm);
      REG_STS: reg_word = 32'(sts);
      default: reg_word = '0;
    endcase
  end

  ////////////////////
  // configuration writes
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      cfg <= '0;
    end else if (bus_req.wen && !sel_tbl) begin
      case (idx)
        REG_CTL: begin
          cfg.ben <= bus_req.wdata[0];
          cfg.inf <= bus_req.wdata[1];
        end
        REG_TRG: cfg.trg_msk <= bus_req.wdata[7:0] & TRG_VLD;
        REG_SIZ: cfg.siz <= bus_req.wdata[ASG_CWM+ASG_CWF-1:0];
        REG_STP: cfg.stp <= bus_req.wdata[ASG_CWM+ASG_CWF-1:0];
        REG_OFF: cfg.off <= bus_req.wdata[ASG_CWM+ASG_CWF-1:0];
        REG_BDL: cfg.bdl <= bus_req.wdata[ASG_CWM-1:0];
        REG_BLN: cfg.bln <= bus_req.wdata[ASG_CWL-1:0];
        REG_BNM: cfg.bnm <= bus_req.wdata[ASG_CWN-1:0];
        default: ;
      endcase
    end
  end

  // ack one cycle after either strobe
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ack    <= 1'b0;
      rd_tbl <= 1'b0;
    end else begin
      ack <= bus_req.wen | bus_req.ren;
      if (bus_req.ren) rd_tbl <= sel_tbl;
    end
  end

  // register word captured with the strobe
  always_ff @(posedge sto) begin
    if (bus_req.ren) rd_reg <= reg_word;
  end

  // table word arrives in the ack cycle
  assign rdata = rd_tbl ? {{(32-ASG_DW){1'b0}}, tbl_rdata} : rd_reg;

endmodule

`default_nettype wire

// File: hw/asg_table.sv
// waveform sample memory, written and read back from the bus and read by the stream pointer
`default_nettype none

module asg_table (
  input  logic                        sto,
  input  logic                        we,
  input  logic [asg_pkg::ASG_CWM-1:0] waddr,
  input  logic [asg_pkg::ASG_DW-1:0]  wdata,
  input  logic [asg_pkg::ASG_CWM-1:0] bus_raddr,
  input  logic                        ren,
  input  logic [asg_pkg::ASG_CWM-1:0] raddr,
  output logic [asg_pkg::ASG_DW-1:0]  bus_rdata,
  output logic [asg_pkg::ASG_DW-1:0]  rdata
);
  import asg_pkg::*;

  // one sample per table entry
  logic [ASG_DW-1:0] mem [2**ASG_CWM];

  ////////////////////
  // bus port

  always_ff @(posedge sto) begin
    if (we) mem[waddr] <= wdata;
  end

  // free running read, used only in the ack cycle
  always_ff @(posedge sto) begin
    bus_rdata <= mem[bus_raddr];
  end

  ////////////////////
  // stream port

  // holds the last sample when ren is low
  // so idle burst phases repeat it and stalls keep it
  always_ff @(posedge sto) begin
    if (ren) rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: hw/asg_pointer.sv
// fixed-point read pointer with modulo wrap, registers the table address for the stream read
`default_nettype none

module asg_pointer (
  input  logic                        sto,
  input  logic                        ctl_rst,
  input  asg_pkg::asg_cfg_t           cfg,
  input  asg_pkg::asg_ctl_t           ctl,
  output logic [asg_pkg::ASG_CWM-1:0] raddr,
  output logic                        ren
);
  import asg_pkg::*;

  // pointer width, integer and fraction
  localparam int unsigned PW = ASG_CWM + ASG_CWF;

  logic [PW-1:0]    ptr_cur;
  logic [PW:0]      ptr_nxt;
  logic [ASG_CWM:0] tbl_len;
  logic [PW:0]      ptr_len;
  logic [PW:0]      ptr_wrp;
  logic             ren_q;

  // step and wrap length in pointer units
  assign ptr_nxt = {1'b0, ptr_cur} + {1'b0, cfg.stp} + 1'b1;
  assign tbl_len = {1'b0, cfg.siz[ASG_CWM-1:0]} + 1'b1;
  assign ptr_len = {tbl_len, {ASG_CWF{1'b0}}};
  // value after one wrap
  assign ptr_wrp = ptr_nxt - ptr_len;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
      ren_q   <= 1'b0;
    end else if (ctl.rdy) begin
      // trigger restarts at the phase offset
      if (ctl.trg) begin
        ptr_cur <= cfg.off;
      end else if (ctl.aen) begin
        ptr_cur <= (ptr_nxt >= ptr_len) ? ptr_wrp[PW-1:0] : ptr_nxt[PW-1:0];
      end
      // read stage follows address stage
      ren_q <= ctl.aen;
    end
  end

  // address stage, integer part only
  always_ff @(posedge sto) begin
    if (ctl.rdy && ctl.aen) raddr <= ptr_cur[PW-1 -: ASG_CWM];
  end

  // no table read while stalled
  assign ren = ren_q & ctl.rdy;

endmodule

`default_nettype wire

// File: hw/asg_burst_fsm.sv
// trigger masking, run state and burst counters, drives pipeline control and interrupt strobes
`default_nettype none

module asg_burst_fsm #(
  parameter int unsigned TN = 1
) (
  input  logic              sto,
  input  logic              ctl_rst,
  input  logic [TN-1:0]     trg_in,
  input  asg_pkg::asg_cfg_t cfg,
  input  logic              rdy,
  output asg_pkg::asg_ctl_t ctl,
  output asg_pkg::asg_sts_t sts,
  output logic              irq_trg,
  output logic              irq_stp
);

  logic trg_hit;
  logic end_bdl;
  logic end_bln;
  logic end_bnm;
  logic rpt;
  logic evt;
  logic aen;

  ////////////////////
  // events

  // any enabled trigger input
  assign trg_hit = |(trg_in & cfg.trg_msk[TN-1:0]);

  // counter end flags
  assign end_bdl = (sts.bln == 16'(cfg.bdl));
  assign end_bln = (sts.bln == cfg.bln);
  assign end_bnm = (sts.bnm == cfg.bnm) & ~cfg.inf;

  // period end repeats the burst
  assign rpt = sts.run & cfg.ben & end_bln;
  // external triggers ignored while running
  assign evt = sts.run ? rpt : trg_hit;

  ////////////////////
  // state

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      aen <= 1'b0;
      sts <= '0;
    end else if (rdy) begin
      if (evt) begin
        if (sts.run) begin
          // next period, or stop after the final one
          aen     <= ~end_bnm;
          sts.run <= ~end_bnm;
          sts.bnm <= sts.bnm + {{($bits(sts.bnm)-1){1'b0}}, ~cfg.inf};
        end else begin
          // start from idle
          aen     <= 1'b1;
          sts.run <= 1'b1;
          sts.bnm <= '0;
        end
        sts.bln <= '0;
      end else if (sts.run && cfg.ben) begin
        // data phase ends after bdl, idle phase repeats the sample
        if (end_bdl) aen <= 1'b0;
        sts.bln <= sts.bln + 1'b1;
      end
    end
  end

  // stop strobe, one cycle per finished sequence
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      irq_stp <= 1'b0;
    end else begin
      irq_stp <= rdy & ctl.lst;
    end
  end

  ////////////////////
  // outputs

  assign ctl.trg = evt;
  assign ctl.aen = aen;
  assign ctl.run = sts.run;
  // last cycle of the final period
  assign ctl.lst = rpt & end_bnm;
  assign ctl.rdy = rdy;

  // taken start or repeat event
  assign irq_trg = evt & rdy;

endmodule

`default_nettype wire

// File: hw/asg_stream_out.sv
// output stage of the sample stream, valid and last pipeline, stall term and trigger output
`default_nettype none

module asg_stream_out (
  input  logic                       sto,
  input  logic                       ctl_rst,
  input  asg_pkg::asg_ctl_t          ctl,
  input  logic [asg_pkg::ASG_DW-1:0] rdata,
  input  logic                       sto_ready,
  output logic                       rdy,
  output logic                       sto_valid,
  output logic                       sto_last,
  output logic [asg_pkg::ASG_DW-1:0] sto_data,
  output logic                       trg_out
);

  // bit 0 address stage, bit 1 read stage
  logic [1:0] vld_p;
  logic [1:0] lst_p;
  // taken trigger, address stage
  logic       trg_d;

  // pipeline moves unless holding an unaccepted sample
  assign rdy = sto_ready | ~sto_valid;

  ////////////////////
  // valid and last

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      vld_p     <= '0;
      lst_p     <= '0;
      sto_valid <= 1'b0;
      sto_last  <= 1'b0;
    end else if (rdy) begin
      vld_p     <= {vld_p[0], ctl.run};
      lst_p     <= {lst_p[0], ctl.lst};
      sto_valid <= vld_p[1];
      sto_last  <= lst_p[1];
    end
  end

  // output data stage
  always_ff @(posedge sto) begin
    if (rdy) sto_data <= rdata;
  end

  ////////////////////
  // trigger out
  // one cycle pulse per taken event, never stretched by a stall
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      trg_d   <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      trg_d   <= ctl.trg & rdy;
      trg_out <= trg_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/asg_top.sv
// generator top level, ties the bus registers, table, pointer, burst FSM and stream output together
`default_nettype none

module asg_top #(
  parameter int unsigned TN = 2
) (
  input  logic                       sto,
  input  logic                       ctl_rst,
  input  asg_pkg::asg_bus_req_t      bus_req,
  input  logic [TN-1:0]              trg_in,
  input  logic                       sto_ready,
  output logic [31:0]                rdata,
  output logic                       ack,
  output logic                       sto_valid,
  output logic [asg_pkg::ASG_DW-1:0] sto_data,
  output logic                       sto_last,
  output logic                       trg_out,
  output logic                       irq_trg,
  output logic                       irq_stp
);
  import asg_pkg::*;

  // configuration and status
  asg_cfg_t           cfg;
  asg_sts_t           sts;
  // FSM control and stall
  asg_ctl_t           ctl;
  logic               rdy;
  // table bus port
  logic               tbl_we;
  logic [ASG_DW-1:0]  tbl_bus_rdata;
  // table stream port
  logic [ASG_CWM-1:0] tbl_raddr;
  logic               tbl_ren;
  logic [ASG_DW-1:0]  tbl_rdata;

  asg_regs #(
    .TN (TN)
  ) asg_regs_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_req   (bus_req),
    .sts       (sts),
    .tbl_rdata (tbl_bus_rdata),
    .cfg       (cfg),
    .tbl_we    (tbl_we),
    .rdata     (rdata),
    .ack       (ack)
  );

  // bus word address doubles as table index
  asg_table asg_table_inst (
    .sto       (sto),
    .we        (tbl_we),
    .waddr     (bus_req.addr[ASG_CWM-1:0]),
    .wdata     (bus_req.wdata[ASG_DW-1:0]),
    .bus_raddr (bus_req.addr[ASG_CWM-1:0]),
    .ren       (tbl_ren),
    .raddr     (tbl_raddr),
    .bus_rdata (tbl_bus_rdata),
    .rdata     (tbl_rdata)
  );

  asg_pointer asg_pointer_inst (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .cfg     (cfg),
    .ctl     (ctl),
    .raddr   (tbl_raddr),
    .ren     (tbl_ren)
  );

  asg_burst_fsm #(
    .TN (TN)
  ) asg_burst_fsm_inst (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .trg_in  (trg_in),
    .cfg     (cfg),
    .rdy     (rdy),
    .ctl     (ctl),
    .sts     (sts),
    .irq_trg (irq_trg),
    .irq_stp (irq_stp)
  );

  asg_stream_out asg_stream_out_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .ctl       (ctl),
    .rdata     (tbl_rdata),
    .sto_ready (sto_ready),
    .rdy       (rdy),
    .sto_valid (sto_valid),
    .sto_last  (sto_last),
    .sto_data  (sto_data),
    .trg_out   (trg_out)
  );

endmodule

`default_nettype wire

// File: dv/asg_assertions.sv
// stream and interrupt protocol checks, bound into the generator top level
`default_nettype none

module asg_assertions (
  input logic                       sto,
  input logic                       ctl_rst,
  input logic                       valid,
  input logic                       ready,
  input logic [asg_pkg::ASG_DW-1:0] data,
  input logic                       last,
  input logic                       stp
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // stream holds while stalled
  stall_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    valid && !ready |=> $stable(data) && $stable(last))
    else $error("stream data or last changed during a stall");

  // valid low out of reset
  reset_idle: assert property (@(posedge sto) ctl_rst |=> !valid)
    else $error("stream valid high after reset");

  ////////////////////
  // stop strobe is a single cycle
  stp_single: assert property (@(posedge sto) disable iff (ctl_rst) stp |=> !stp)
    else $error("irq_stp high for two cycles");

endmodule

// one instance sees the stream output and the FSM stop strobe
bind asg_top asg_assertions proto_chk (
  .sto     (sto),
  .ctl_rst (ctl_rst),
  .valid   (sto_valid),
  .ready   (sto_ready),
  .data    (sto_data),
  .last    (sto_last),
  .stp     (irq_stp)
);

`default_nettype wire

// File: dv/asg_tb.sv
// generator testbench, runs the records of the test data file against the top level
`default_nettype none

module asg_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import asg_pkg::*;

  logic              sto;
  logic              ctl_rst;
  asg_bus_req_t      bus_req;
  logic [1:0]        trg_in;
  logic              sto_ready;
  logic [31:0]       rdata;
  logic              ack;
  logic              sto_valid;
  logic [ASG_DW-1:0] sto_data;
  logic              sto_last;
  logic              trg_out;
  logic              irq_trg;
  logic              irq_stp;

  integer seed = 66417;
  int     errors;
  int     tests;
  int     cycles;
  int     limit;
  // pulse counters
  int     n_trg;
  int     n_tout;
  int     n_stp;
  // received samples, last flag on top
  logic [ASG_DW:0] got_q[$];
  string           recs[$];

  asg_top #(
    .TN (2)
  ) asg_top_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_req   (bus_req),
    .trg_in    (trg_in),
    .sto_ready (sto_ready),
    .rdata     (rdata),
    .ack       (ack),
    .sto_valid (sto_valid),
    .sto_data  (sto_data),
    .sto_last  (sto_last),
    .trg_out   (trg_out),
    .irq_trg   (irq_trg),
    .irq_stp   (irq_stp)
  );

  initial begin
    sto = 1'b0;
    forever #5 sto = ~sto;
  end

  // random back-pressure, ready about 3 of 4 cycles
  always @(posedge sto) begin
    #1;
    sto_ready = ($random(seed) & 3) != 0;
  end

  ////////////////////
  // monitor, sampled mid-cycle
  always @(negedge sto) begin
    if (!ctl_rst) begin
      if (sto_valid && sto_ready) got_q.push_back({sto_last, sto_data});
      if (irq_trg) n_trg++;
      if (trg_out) n_tout++;
      if (irq_stp) n_stp++;
    end
  end

  // run limit
  always @(posedge sto) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  // table pattern from the word address
  function automatic logic [31:0] fill_word(logic [9:0] addr);
    logic [13:0] w;
    w = 14'h2000 + 14'(addr[8:0]) * 14'h101;
    return 32'(w);
  endfunction

  ////////////////////
  // bus
  task automatic bus_access(logic wr, logic [9:0] addr, logic [31:0] data,
                            logic chk, logic [31:0] exp);
    @(posedge sto);
    #1;
    bus_req.wen   = wr;
    bus_req.ren   = !wr;
    bus_req.addr  = addr;
    bus_req.wdata = data;
    @(posedge sto);
    #1;
    bus_req.wen = 1'b0;
    bus_req.ren = 1'b0;
    @(negedge sto);
    if (ack !== 1'b1) report_mismatch("ack", 32'(ack), 32'd1);
    if (chk && rdata !== exp) report_mismatch("rdata", rdata, exp);
    @(negedge sto);
    if (ack !== 1'b0) report_mismatch("ack", 32'(ack), 32'd0);
  endtask

  task automatic fill_table(int count);
    logic [9:0] addr;
    for (int i = 0; i < count; i++) begin
      addr = 10'h200 | 10'(i);
      bus_access(1'b1, addr, fill_word(addr), 1'b0, 32'd0);
    end
  endtask

  // one cycle trigger, then count the strobes it causes
  task automatic pulse_trigger(logic [1:0] vec, int exp);
    @(posedge sto);
    #1;
    n_trg  = 0;
    n_tout = 0;
    trg_in = vec;
    @(posedge sto);
    #1;
    trg_in = '0;
    repeat (6) @(negedge sto);
    if (n_trg != exp) report_mismatch("irq_trg count", n_trg, exp);
    if (n_tout != exp) report_mismatch("trg_out count", n_tout, exp);
    if (exp == 0 && got_q.size() != 0) begin
      errors++;
      $display("masked trigger started the stream at %0t", $time);
    end
  endtask

  task automatic expect_sample(logic [31:0] data, logic [31:0] last);
    logic [ASG_DW:0] s;
    while (got_q.size() == 0) @(negedge sto);
    s = got_q.pop_front();
    if (s[ASG_DW-1:0] !== data[ASG_DW-1:0]) report_mismatch("sto_data", 32'(s[ASG_DW-1:0]), data);
    if (s[ASG_DW] !== last[0]) report_mismatch("sto_last", 32'(s[ASG_DW]), last);
  endtask

  task automatic pulse_reset();
    @(posedge sto);
    #1;
    ctl_rst = 1'b1;
    repeat (2) @(posedge sto);
    #1;
    ctl_rst = 1'b0;
    got_q.delete();
    n_stp = 0;
  endtask

  // stream must stay quiet once a test is over
  task automatic end_test(int exp_stp);
    repeat (30) @(negedge sto);
    if (got_q.size() != 0) begin
      errors++;
      $display("%0d unexpected samples at end of test, time %0t", got_q.size(), $time);
    end
    if (n_stp != exp_stp) report_mismatch("irq_stp count", n_stp, exp_stp);
    tests++;
    $display("test %0d done, errors so far %0d", tests, errors);
    got_q.delete();
    n_stp = 0;
  endtask

  ////////////////////
  // main sequence
  initial begin
    int          fd;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    ctl_rst   = 1'b1;
    bus_req   = '0;
    trg_in    = '0;
    sto_ready = 1'b0;
    errors    = 0;
    tests     = 0;
    cycles    = 0;
    limit     = 0;
    n_trg     = 0;
    n_tout    = 0;
    n_stp     = 0;
    fd = $fopen("dv/asg_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open dv/asg_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") recs.push_back(line);
      end
      $fclose(fd);
    end
    limit = 40 * recs.size() + 200;
    repeat (16) @(posedge sto);
    #1;
    ctl_rst = 1'b0;
    foreach (recs[i]) begin
      a = '0;
      b = '0;
      void'($sscanf(recs[i], "%c %h %h", kind, a, b));
      case (kind)
        "W": bus_access(1'b1, a[9:0], b, 1'b0, 32'd0);
        "R": bus_access(1'b0, a[9:0], 32'd0, 1'b1, b);
        "F": fill_table(a);
        "T": pulse_trigger(a[1:0], b);
        "S": expect_sample(a, b);
        "X": pulse_reset();
        "E": end_test(a);
        default: begin
          errors++;
          $display("unknown record in test data: %s", recs[i]);
        end
      endcase
    end
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/asg_testdata.txt
# type a b, all hex: W addr data | R addr expected | F table entries | T trg_in pulses
# S sample last | X reset pulse | E irq_stp count, closes a test
F 10
R 200 2000
R 20f 2f0f
R 205 2505
W 003 2ff
R 003 2ff
E 0
# periodic, step 3 from index 5
W 001 1
W 002 f
W 003 2ff
W 004 500
T 1 1
S 2505 0
S 2808 0
S 2b0b 0
S 2e0e 0
S 2101 0
S 2404 0
S 2707 0
S 2a0a 0
X
E 0
# half step from index 2
W 001 1
W 002 f
W 003 7f
W 004 200
T 1 1
S 2202 0
S 2202 0
S 2303 0
S 2303 0
S 2404 0
S 2404 0
X
E 0
# input 1 masked, input 0 starts
W 001 1
W 002 f
W 003 ff
W 004 0
T 2 0
T 1 1
S 2000 0
S 2101 0
S 2202 0
X
E 0
# burst, two periods of eight from index 1
W 001 1
W 002 f
W 003 ff
W 004 100
W 005 3
W 006 7
W 007 1
W 000 1
T 1 1
S 2101 0
S 2202 0
S 2303 0
S 2404 0
S 2404 0
S 2404 0
S 2404 0
S 2404 0
S 2101 0
S 2202 0
S 2303 0
S 2404 0
S 2404 0
S 2404 0
S 2404 0
S 2404 1
R 008 2
E 1

// File: files.f
hw/asg_pkg.sv
hw/asg_regs.sv
hw/asg_table.sv
hw/asg_pointer.sv
hw/asg_burst_fsm.sv
hw/asg_stream_out.sv
hw/asg_top.sv
dv/asg_assertions.sv
dv/asg_tb.sv
